// ==== verilog/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// frame geometry, pixels per row and rows per frame
`define CONV_IMAGE_WIDTH 16
`define CONV_IMAGE_HEIGHT 16

// square kernel side
`define CONV_KERNEL 7

// channel counts
`define CONV_CHANNELS_IN 3
`define CONV_CHANNELS_OUT 4

// signed data widths
`define CONV_PIXEL_BITS 8
`define CONV_WEIGHT_BITS 8
`define CONV_RESULT_BITS 16

`endif

// ==== verilog/conv_types_pkg.sv ====
`include "conv_config.svh"

package conv_types_pkg;

	// 3 x 49 products of 8x8 bits stay below 2^23
	localparam int PSUM_BITS = 24;

	////////////////////////////////////////////////////////////
	// scalar words
	////////////////////////////////////////////////////////////
	typedef logic signed [`CONV_PIXEL_BITS-1:0] pixel_t;
	typedef logic signed [`CONV_WEIGHT_BITS-1:0] weight_t;
	typedef logic signed [PSUM_BITS-1:0] psum_t;
	typedef logic signed [`CONV_RESULT_BITS-1:0] result_t;

	// input channel select, 0 to 2
	typedef logic [1:0] channel_idx_t;

	////////////////////////////////////////////////////////////
	// 7x7 blocks, indexed [row][col] from the top-left corner
	////////////////////////////////////////////////////////////
	typedef pixel_t [`CONV_KERNEL-1:0][`CONV_KERNEL-1:0] window_t;
	typedef weight_t [`CONV_KERNEL-1:0][`CONV_KERNEL-1:0] kernel_t;

endpackage

// ==== verilog/conv_stream_pkg.sv ====
`include "conv_config.svh"

package conv_stream_pkg;

	// one raster pixel of one input channel
	typedef struct packed {
		logic strobe;
		conv_types_pkg::pixel_t pixel;
	} pixel_stream_t;

	// one kernel weight during loading
	typedef struct packed {
		logic strobe;
		conv_types_pkg::weight_t weight;
	} weight_stream_t;

	// full 7x7 window of one input channel
	typedef struct packed {
		logic strobe;
		conv_types_pkg::channel_idx_t channel;
		conv_types_pkg::window_t window;
	} window_stream_t;

	// per input channel partial sums, one per output channel
	typedef struct packed {
		logic strobe;
		conv_types_pkg::channel_idx_t channel;
		conv_types_pkg::psum_t [`CONV_CHANNELS_OUT-1:0] sums;
	} psum_stream_t;

	// final saturated outputs of one window position
	typedef struct packed {
		logic strobe;
		conv_types_pkg::result_t [`CONV_CHANNELS_OUT-1:0] results;
	} result_stream_t;

endpackage

// ==== verilog/conv_weight_store.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_weight_store (
	input logic clk,
	input logic reset,
	input conv_stream_pkg::weight_stream_t weight_in,
	input conv_types_pkg::channel_idx_t channel,
	output conv_types_pkg::kernel_t kernels [`CONV_CHANNELS_OUT]
);
	import conv_types_pkg::*;

	localparam int TAPS = `CONV_KERNEL * `CONV_KERNEL;
	localparam int WEIGHTS = `CONV_CHANNELS_OUT * `CONV_CHANNELS_IN * TAPS;
	localparam int ADDR_BITS = $clog2(WEIGHTS);

	// flat store, out channel major, then in channel, row, col
	weight_t mem [WEIGHTS];
	logic [ADDR_BITS-1:0] addr;

	////////////////////////////////////////////////////////////
	// sequential load
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (weight_in.strobe) begin
			mem[addr] <= weight_in.weight;
		end
		if (reset) begin
			addr <= '0;
		end else if (weight_in.strobe) begin
			if (addr == ADDR_BITS'(WEIGHTS - 1)) begin
				addr <= '0;
			end else begin
				addr <= addr + 1'b1;
			end
		end
	end

	// all taps of the selected input channel, for every output channel
	always_comb begin
		for (int oc = 0; oc < `CONV_CHANNELS_OUT; oc++) begin
			for (int r = 0; r < `CONV_KERNEL; r++) begin
				for (int c = 0; c < `CONV_KERNEL; c++) begin
					kernels[oc][r][c] =
						mem[(oc * `CONV_CHANNELS_IN + int'(channel)) * TAPS + r * `CONV_KERNEL + c];
				end
			end
		end
	end

endmodule

// ==== verilog/conv_window_buffer.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_window_buffer (
	input logic clk,
	input logic reset,
	input conv_stream_pkg::pixel_stream_t pixel_in,
	output conv_stream_pkg::window_stream_t window_out
);
	import conv_types_pkg::*;

	localparam int K = `CONV_KERNEL;
	localparam int W = `CONV_IMAGE_WIDTH;
	localparam int COL_BITS = $clog2(`CONV_IMAGE_WIDTH);
	localparam int ROW_BITS = $clog2(`CONV_IMAGE_HEIGHT);
	// with the incoming pixel the span is 6 rows plus 7 pixels
	localparam int DEPTH = (K - 1) * W + K - 1;

	channel_idx_t ch_cnt;
	logic [COL_BITS-1:0] col_cnt;
	logic [ROW_BITS-1:0] row_cnt;
	logic pos_valid;

	// one history per input channel, index 0 is the newest
	pixel_t chain [`CONV_CHANNELS_IN][DEPTH];
	window_t taps;

	////////////////////////////////////////////////////////////
	// raster counters, channel fastest
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			ch_cnt <= '0;
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (pixel_in.strobe) begin
			if (ch_cnt == channel_idx_t'(`CONV_CHANNELS_IN - 1)) begin
				ch_cnt <= '0;
				if (col_cnt == COL_BITS'(`CONV_IMAGE_WIDTH - 1)) begin
					col_cnt <= '0;
					if (row_cnt == ROW_BITS'(`CONV_IMAGE_HEIGHT - 1)) begin
						row_cnt <= '0;
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end else begin
				ch_cnt <= ch_cnt + 1'b1;
			end
		end
	end

	// no padding, window complete from row 6 col 6 on
	assign pos_valid = (row_cnt >= ROW_BITS'(K - 1)) && (col_cnt >= COL_BITS'(K - 1));

	////////////////////////////////////////////////////////////
	// line buffer shift, only the strobed channel moves
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (pixel_in.strobe) begin
			for (int ch = 0; ch < `CONV_CHANNELS_IN; ch++) begin
				if (ch_cnt == channel_idx_t'(ch)) begin
					chain[ch][0] <= pixel_in.pixel;
					for (int i = 1; i < DEPTH; i++) begin
						chain[ch][i] <= chain[ch][i-1];
					end
				end
			end
		end
	end

	// tap at (r, c) lies (6-r) rows and (6-c) pixels back
	always_comb begin
		int offset;
		for (int r = 0; r < K; r++) begin
			for (int c = 0; c < K; c++) begin
				offset = (K - 1 - r) * W + (K - 1 - c);
				if (offset == 0) begin
					taps[r][c] = pixel_in.pixel;
				end else begin
					taps[r][c] = chain[ch_cnt][offset-1];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pixel_in.strobe) begin
			window_out.channel <= ch_cnt;
			window_out.window <= taps;
		end
		if (reset) begin
			window_out.strobe <= 1'b0;
		end else begin
			window_out.strobe <= pixel_in.strobe && pos_valid;
		end
	end

endmodule

// ==== verilog/conv_tap_mac.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_tap_mac (
	input logic clk,
	input logic reset,
	input conv_stream_pkg::window_stream_t window_in,
	input conv_types_pkg::kernel_t kernels [`CONV_CHANNELS_OUT],
	output conv_stream_pkg::psum_stream_t psum_out
);
	import conv_types_pkg::*;

	psum_t sums [`CONV_CHANNELS_OUT];

	////////////////////////////////////////////////////////////
	// 49 products per output channel summed in one adder tree
	////////////////////////////////////////////////////////////
	always_comb begin
		for (int oc = 0; oc < `CONV_CHANNELS_OUT; oc++) begin
			sums[oc] = '0;
			for (int r = 0; r < `CONV_KERNEL; r++) begin
				for (int c = 0; c < `CONV_KERNEL; c++) begin
					sums[oc] = sums[oc] + psum_t'(window_in.window[r][c]) *
						psum_t'(kernels[oc][r][c]);
				end
			end
		end
	end

	// output register with the channel tag next to the sums
	always_ff @(posedge clk) begin
		if (window_in.strobe) begin
			psum_out.channel <= window_in.channel;
			for (int oc = 0; oc < `CONV_CHANNELS_OUT; oc++) begin
				psum_out.sums[oc] <= sums[oc];
			end
		end
		if (reset) begin
			psum_out.strobe <= 1'b0;
		end else begin
			psum_out.strobe <= window_in.strobe;
		end
	end

endmodule

// ==== verilog/conv_channel_adder.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_channel_adder (
	input logic clk,
	input logic reset,
	input conv_stream_pkg::psum_stream_t psum_in,
	output conv_stream_pkg::result_stream_t result_out
);
	import conv_types_pkg::*;

	localparam psum_t SAT_MAX = psum_t'(2 ** (`CONV_RESULT_BITS - 1) - 1);
	localparam psum_t SAT_MIN = psum_t'(-(2 ** (`CONV_RESULT_BITS - 1)));
	localparam channel_idx_t LAST_CH = channel_idx_t'(`CONV_CHANNELS_IN - 1);

	psum_t acc [`CONV_CHANNELS_OUT];
	psum_t total [`CONV_CHANNELS_OUT];

	// clamp to the signed 16 bit range
	function automatic result_t saturate(input psum_t value);
		if (value > SAT_MAX) begin
			return result_t'(SAT_MAX);
		end else if (value < SAT_MIN) begin
			return result_t'(SAT_MIN);
		end
		return result_t'(value);
	endfunction

	always_comb begin
		for (int oc = 0; oc < `CONV_CHANNELS_OUT; oc++) begin
			total[oc] = acc[oc] + psum_in.sums[oc];
		end
	end

	////////////////////////////////////////////////////////////
	// channel 0 loads, channels 1 and 2 add, channel 2 emits
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (psum_in.strobe) begin
			for (int oc = 0; oc < `CONV_CHANNELS_OUT; oc++) begin
				acc[oc] <= (psum_in.channel == '0) ? psum_in.sums[oc] : total[oc];
				if (psum_in.channel == LAST_CH) begin
					result_out.results[oc] <= saturate(total[oc]);
				end
			end
		end
		if (reset) begin
			result_out.strobe <= 1'b0;
		end else begin
			result_out.strobe <= psum_in.strobe && (psum_in.channel == LAST_CH);
		end
	end

endmodule

// ==== verilog/conv_layer_top.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_layer_top (
	input logic clk,
	input logic reset,
	input conv_stream_pkg::pixel_stream_t pixel_in,
	input conv_stream_pkg::weight_stream_t weight_in,
	output conv_stream_pkg::result_stream_t result_out
);
	import conv_types_pkg::*;
	import conv_stream_pkg::*;

	window_stream_t window;
	psum_stream_t psum;
	kernel_t kernels [`CONV_CHANNELS_OUT];

	////////////////////////////////////////////////////////////
	// weights, read by the channel of the window in flight
	////////////////////////////////////////////////////////////
	conv_weight_store weight_store_inst (
		.clk       (clk),
		.reset     (reset),
		.weight_in (weight_in),
		.channel   (window.channel),
		.kernels   (kernels)
	);

	////////////////////////////////////////////////////////////
	// pixel path, window then mac then channel sum
	////////////////////////////////////////////////////////////
	conv_window_buffer window_buffer_inst (
		.clk        (clk),
		.reset      (reset),
		.pixel_in   (pixel_in),
		.window_out (window)
	);

	conv_tap_mac tap_mac_inst (
		.clk       (clk),
		.reset     (reset),
		.window_in (window),
		.kernels   (kernels),
		.psum_out  (psum)
	);

	conv_channel_adder channel_adder_inst (
		.clk        (clk),
		.reset      (reset),
		.psum_in    (psum),
		.result_out (result_out)
	);

endmodule

// ==== tests/conv_layer_checker.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_layer_checker (
	input logic clk,
	input logic reset,
	input conv_stream_pkg::pixel_stream_t pixel_in,
	input conv_stream_pkg::weight_stream_t weight_in,
	input conv_stream_pkg::result_stream_t result_out,
	output int error_count,
	output int result_count,
	output int pending
);
	import conv_types_pkg::*;

	localparam int K = `CONV_KERNEL;
	localparam int TAPS = K * K;
	localparam int CIN = `CONV_CHANNELS_IN;
	localparam int COUT = `CONV_CHANNELS_OUT;
	localparam int WEIGHTS = COUT * CIN * TAPS;
	localparam int RES_BITS = `CONV_RESULT_BITS;

	// weight model in out channel, in channel, row, col order
	int weights [WEIGHTS];
	int image [CIN][`CONV_IMAGE_HEIGHT][`CONV_IMAGE_WIDTH];
	int waddr = 0;
	int ch = 0;
	int col = 0;
	int row = 0;
	int cycle = 0;
	int errors = 0;
	int results = 0;

	// expected results with the cycle they are due
	int due_q [$];
	logic [COUT*RES_BITS-1:0] expect_q [$];

	assign error_count = errors;
	assign result_count = results;

	function automatic int clamp_result(input int value);
		int hi;
		int lo;
		hi = 2 ** (RES_BITS - 1) - 1;
		lo = -(2 ** (RES_BITS - 1));
		if (value > hi) return hi;
		if (value < lo) return lo;
		return value;
	endfunction

	// all three channels of this position are in the image by now
	task automatic predict_position();
		logic [COUT*RES_BITS-1:0] packed_res;
		int sum;
		for (int oc = 0; oc < COUT; oc++) begin
			sum = 0;
			for (int ic = 0; ic < CIN; ic++) begin
				for (int r = 0; r < K; r++) begin
					for (int c = 0; c < K; c++) begin
						sum += image[ic][row-K+1+r][col-K+1+c] *
							weights[(oc * CIN + ic) * TAPS + r * K + c];
					end
				end
			end
			packed_res[oc*RES_BITS +: RES_BITS] = RES_BITS'(clamp_result(sum));
		end
		expect_q.push_back(packed_res);
		due_q.push_back(cycle + 3);
	endtask

	task automatic check_output();
		logic [COUT*RES_BITS-1:0] expected;
		int due;
		if (result_out.strobe) begin
			results++;
			if (due_q.size() == 0) begin
				$display("%0t: result strobe arrived with no window pending", $time);
				errors++;
			end else begin
				due = due_q.pop_front();
				expected = expect_q.pop_front();
				if (due != cycle) begin
					$display("%0t: result strobe at cycle %0d, due at cycle %0d",
						$time, cycle, due);
					errors++;
				end
				for (int oc = 0; oc < COUT; oc++) begin
					if (result_out.results[oc] != expected[oc*RES_BITS +: RES_BITS]) begin
						$display("mismatch at %0t: result_out.results[%0d] got %0d expected %0d",
							$time, oc, result_out.results[oc],
							$signed(expected[oc*RES_BITS +: RES_BITS]));
						errors++;
					end
				end
			end
		end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
			$display("%0t: result strobe missing, it was due at cycle %0d", $time, due_q[0]);
			errors++;
			void'(due_q.pop_front());
			void'(expect_q.pop_front());
		end
	endtask

	////////////////////////////////////////////////////////////
	// sample at the rising edge after inputs settle on the falling edge
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		cycle++;
		if (reset) begin
			waddr = 0;
			ch = 0;
			col = 0;
			row = 0;
			due_q.delete();
			expect_q.delete();
		end else begin
			check_output();
			if (weight_in.strobe) begin
				weights[waddr] = int'(weight_in.weight);
				waddr = (waddr == WEIGHTS - 1) ? 0 : waddr + 1;
			end
			if (pixel_in.strobe) begin
				image[ch][row][col] = int'(pixel_in.pixel);
				if (ch == CIN - 1 && row >= K - 1 && col >= K - 1) begin
					predict_position();
				end
				if (ch == CIN - 1) begin
					ch = 0;
					if (col == `CONV_IMAGE_WIDTH - 1) begin
						col = 0;
						row = (row == `CONV_IMAGE_HEIGHT - 1) ? 0 : row + 1;
					end else begin
						col++;
					end
				end else begin
					ch++;
				end
			end
		end
		pending = due_q.size();
	end

endmodule

// ==== tests/conv_layer_tb.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_layer_tb;
	import conv_types_pkg::*;
	import conv_stream_pkg::*;

	localparam int K = `CONV_KERNEL;
	localparam int WEIGHTS = `CONV_CHANNELS_OUT * `CONV_CHANNELS_IN * K * K;
	localparam int FRAME_PIXELS = `CONV_IMAGE_WIDTH * `CONV_IMAGE_HEIGHT * `CONV_CHANNELS_IN;
	localparam int FRAME_RESULTS = (`CONV_IMAGE_WIDTH - K + 1) * (`CONV_IMAGE_HEIGHT - K + 1);
	localparam int DRAIN_LIMIT = 50;

	// stimulus value modes
	localparam int VALUE_RANDOM = 0;
	localparam int VALUE_MAX = 1;
	localparam int VALUE_MIN = 2;

	logic clk;
	logic reset;
	pixel_stream_t pixel_in;
	weight_stream_t weight_in;
	result_stream_t result_out;
	int error_count;
	int result_count;
	int pending;
	int tb_errors = 0;
	int results_seen = 0;
	integer seed = 32'hbf008828;
	bit ok;

	conv_layer_top conv_layer_top_inst (
		.clk        (clk),
		.reset      (reset),
		.pixel_in   (pixel_in),
		.weight_in  (weight_in),
		.result_out (result_out)
	);

	conv_layer_checker checker_inst (
		.clk          (clk),
		.reset        (reset),
		.pixel_in     (pixel_in),
		.weight_in    (weight_in),
		.result_out   (result_out),
		.error_count  (error_count),
		.result_count (result_count),
		.pending      (pending)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic pick_value(input int mode, output pixel_t value);
		if (mode == VALUE_MAX) begin
			value = pixel_t'(127);
		end else if (mode == VALUE_MIN) begin
			value = pixel_t'(-128);
		end else begin
			value = pixel_t'($random(seed));
		end
	endtask

	// one full weight set, no gaps
	task automatic load_weights(input int mode);
		weight_t value;
		for (int i = 0; i < WEIGHTS; i++) begin
			pick_value(mode, value);
			weight_in.strobe = 1'b1;
			weight_in.weight = value;
			@(negedge clk);
		end
		weight_in.strobe = 1'b0;
	endtask

	// one frame, with up to gap_max idle cycles before each pixel
	task automatic send_frame(input int mode, input int gap_max);
		int gap;
		pixel_t value;
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			gap = {$random(seed)} % (gap_max + 1);
			pixel_in.strobe = 1'b0;
			repeat (gap) @(negedge clk);
			pick_value(mode, value);
			pixel_in.strobe = 1'b1;
			pixel_in.pixel = value;
			@(negedge clk);
		end
		pixel_in.strobe = 1'b0;
	endtask

	// wait for the pipeline to empty, then check the result count
	task automatic drain_results(input int expected, output bit done);
		int waited;
		waited = 0;
		while (pending != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		done = (pending == 0);
		if (!done) begin
			$display("timeout: %0d results still pending after %0d cycles", pending, waited);
			tb_errors++;
		end else if (result_count - results_seen != expected) begin
			$display("wrong number of results: got %0d, expected %0d",
				result_count - results_seen, expected);
			tb_errors++;
		end
		results_seen = result_count;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	task automatic run_sequence(output bit done);
		load_weights(VALUE_RANDOM);
		send_frame(VALUE_RANDOM, 0);
		drain_results(FRAME_RESULTS, done);
		if (!done) return;
		// saturation in both directions
		load_weights(VALUE_MAX);
		send_frame(VALUE_MAX, 0);
		drain_results(FRAME_RESULTS, done);
		if (!done) return;
		send_frame(VALUE_MIN, 0);
		drain_results(FRAME_RESULTS, done);
		if (!done) return;
		// idle gaps, then two frames back to back
		load_weights(VALUE_RANDOM);
		send_frame(VALUE_RANDOM, 3);
		drain_results(FRAME_RESULTS, done);
		if (!done) return;
		send_frame(VALUE_RANDOM, 0);
		send_frame(VALUE_RANDOM, 0);
		drain_results(2 * FRAME_RESULTS, done);
		if (!done) return;
		// new weight set after the load address wrapped
		load_weights(VALUE_RANDOM);
		send_frame(VALUE_RANDOM, 2);
		drain_results(FRAME_RESULTS, done);
	endtask

	initial begin
		pixel_in = '0;
		weight_in = '0;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		run_sequence(ok);
		repeat (5) @(negedge clk);
		$display("results %0d, checker errors %0d, testbench errors %0d",
			result_count, error_count, tb_errors);
		if (ok && error_count == 0 && tb_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/conv_types_pkg.sv
verilog/conv_stream_pkg.sv
verilog/conv_weight_store.sv
verilog/conv_window_buffer.sv
verilog/conv_tap_mac.sv
verilog/conv_channel_adder.sv
verilog/conv_layer_top.sv
tests/conv_layer_checker.sv
tests/conv_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the convolution layer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -j 0 -Wno-fatal --top-module conv_layer_tb -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vconv_layer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	exit 0
fi
exit 1
